//--- rtl/cpuConsts.svh
/*
 * widths, opcodes and ALU op codes for the five-stage integer core
 * opcode and ALU op values follow the existing 32-bit ISA encoding
 * only the subset this core executes is listed here
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and register index widths
`define CPU_XLEN        32
`define CPU_REG_AW      5
// opcode, ALU op and shamt fields are all five bits
`define CPU_FIELD_W     5
`define CPU_IMM_W       17
`define CPU_TGT_W       27

// major opcodes, instruction bits 31:27
`define CPU_OP_ALU      5'b00000
`define CPU_OP_J        5'b00001
`define CPU_OP_BNE      5'b00010
`define CPU_OP_ADDI     5'b00101
`define CPU_OP_BLT      5'b00110
`define CPU_OP_SW       5'b00111
`define CPU_OP_LW       5'b01000

// ALU op field, instruction bits 6:2
`define CPU_ALU_ADD     5'b00000
`define CPU_ALU_SUB     5'b00001
`define CPU_ALU_AND     5'b00010
`define CPU_ALU_OR      5'b00011
`define CPU_ALU_SLL     5'b00100
`define CPU_ALU_SRA     5'b00101
`define CPU_ALU_MUL     5'b00110

// one shift-add iteration per multiplier bit
`define CPU_MUL_STEPS   32

`endif

//--- rtl/cpuPkg.sv
/*
 * shared types of the pipeline: words, register indices, the
 * forwarding select and one struct per stage register
 * the stage structs carry a valid bit and consumers gate on it
 */
`include "cpuConsts.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0] wordT;
    typedef logic [`CPU_REG_AW-1:0] regAddrT;

    // operand source for the execute stage
    typedef enum logic [1:0] {
        none   = 2'd0,
        fromXm = 2'd1,
        fromMw = 2'd2
    } fwdSelT;

    // decoded controls that travel with an instruction
    typedef struct packed {
        logic                    regWrite;
        logic [`CPU_FIELD_W-1:0] aluOp;
        logic                    useImm;
        logic                    memWrite;
        logic                    memRead;
        logic                    isBranchNe;
        logic                    isBranchLt;
        logic                    isJump;
        logic                    isMul;
        logic [`CPU_FIELD_W-1:0] shamt;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } fdRegT;

    // rsVal and rtVal are the values read on register ports A and B
    typedef struct packed {
        logic    valid;
        wordT    pc;
        wordT    rsVal;
        wordT    rtVal;
        wordT    imm;
        wordT    target;
        regAddrT rd;
        regAddrT srcA;
        regAddrT srcB;
        ctrlT    ctrl;
    } dxRegT;

    typedef struct packed {
        logic    valid;
        wordT    result;
        wordT    storeData;
        regAddrT rd;
        logic    regWrite;
        logic    memWrite;
        logic    memRead;
    } xmRegT;

    typedef struct packed {
        logic    valid;
        wordT    result;
        wordT    loadData;
        regAddrT rd;
        logic    regWrite;
        logic    memRead;
    } mwRegT;

    // value that the writeback stage sends to the register file
    function automatic wordT wbValue(mwRegT m);
        return m.memRead ? m.loadData : m.result;
    endfunction

endpackage

//--- rtl/hazardIf.sv
/*
 * hazard status from decode to the controller and the stall,
 * forwarding and multiply controls back to the stages
 * all signals are combinational within one cycle
 */
interface hazardIf import cpuPkg::*; ();

    // source registers of the instruction in decode
    regAddrT srcA;
    regAddrT srcB;
    logic    readA;
    logic    readB;
    // holds for the front end and the decode/execute register
    logic    stallFront;
    logic    mulBusy;
    logic    mulStart;
    logic    mulDone;
    fwdSelT  fwdSelA;
    fwdSelT  fwdSelB;

    modport ctrl (
        input  srcA, srcB, readA, readB,
        output stallFront, mulBusy, mulStart, mulDone, fwdSelA, fwdSelB
    );

    modport fetch (
        input stallFront, mulBusy
    );

    modport decode (
        output srcA, srcB, readA, readB,
        input  stallFront, mulBusy
    );

    modport execute (
        input fwdSelA, fwdSelB, mulStart, mulBusy, mulDone
    );

endinterface

//--- rtl/mulStepCounter.sv
/*
 * multiply step counter
 * done pulses one cycle, exactly CPU_MUL_STEPS cycles after start
 * a new start is not accepted until done has fired
 */
`include "cpuConsts.svh"

module mulStepCounter (
    input  logic clock,
    input  logic rstN,
    input  logic start,
    output logic done
);

    localparam int stepCntW = $clog2(`CPU_MUL_STEPS);

    logic                running;
    logic [stepCntW-1:0] count;

    assign done = running && (count == stepCntW'(`CPU_MUL_STEPS - 1));

    always_ff @(posedge clock) begin
        if (!rstN) begin
            running <= 1'b0;
            count <= '0;
        end else if (start) begin
            running <= 1'b1;
            count <= '0;
        end else if (done) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (!rstN) start |-> !running)
        else $error("multiply started while counter still running");

endmodule

//--- rtl/fetchUnit.sv
/*
 * program counter and fetch/decode register
 * PC counts in words, one instruction per address
 * a redirect clears the instruction being fetched this cycle
 */
module fetchUnit import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    hazardIf.fetch  hz,
    input  logic    redirect,
    input  wordT    redirectPc,
    output wordT    addressImem,
    input  wordT    qImem,
    output fdRegT   fd
);

    wordT pc;
    wordT nextPc;
    logic hold;

    // load-use stall and a running multiply both freeze the front end
    assign hold = hz.stallFront | hz.mulBusy;
    assign nextPc = redirect ? redirectPc : pc + wordT'(1);
    assign addressImem = pc;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= '0;
            fd.valid <= 1'b0;
        end else if (!hold) begin
            pc <= nextPc;
            // instruction fetched behind a taken branch is dropped
            fd.valid <= !redirect;
            fd.pc <= pc;
            fd.instr <= qImem;
        end
    end

    // a load in execute is never a branch, so the two cannot collide
    assert property (@(posedge clock) disable iff (!rstN) !(redirect && hz.stallFront))
        else $error("redirect together with load-use stall");

endmodule

//--- rtl/decodeUnit.sv
/*
 * instruction decode and decode/execute register
 * register file is read combinationally with write-through
 * so no forwarding from writeback into decode is needed
 * unknown opcodes decode as a no-op
 */
`include "cpuConsts.svh"

module decodeUnit import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    hazardIf.decode hz,
    input  fdRegT   fd,
    input  logic    redirect,
    output regAddrT ctrlReadRegA,
    output regAddrT ctrlReadRegB,
    input  wordT    dataReadRegA,
    input  wordT    dataReadRegB,
    output dxRegT   dx
);

    logic [`CPU_FIELD_W-1:0] opcode;
    logic [`CPU_FIELD_W-1:0] aluF;
    logic [`CPU_FIELD_W-1:0] shamtF;
    logic [`CPU_IMM_W-1:0]   immF;
    logic [`CPU_TGT_W-1:0]   tgtF;
    regAddrT rdF;
    regAddrT rsF;
    regAddrT rtF;
    regAddrT idxA;
    regAddrT idxB;
    logic    usesA;
    logic    usesB;
    logic    isBranch;
    ctrlT    ctrl;
    wordT    immExt;
    wordT    tgtExt;

    // fixed field positions of the ISA
    assign opcode = fd.instr[31:27];
    assign rdF    = fd.instr[26:22];
    assign rsF    = fd.instr[21:17];
    assign rtF    = fd.instr[16:12];
    assign shamtF = fd.instr[11:7];
    assign aluF   = fd.instr[6:2];
    assign immF   = fd.instr[`CPU_IMM_W-1:0];
    assign tgtF   = fd.instr[`CPU_TGT_W-1:0];

    assign immExt = {{(`CPU_XLEN - `CPU_IMM_W){immF[`CPU_IMM_W-1]}}, immF};
    // jump target is an absolute word address
    assign tgtExt = {{(`CPU_XLEN - `CPU_TGT_W){1'b0}}, tgtF};

    always_comb begin
        ctrl = '0;
        usesA = 1'b0;
        usesB = 1'b0;
        ctrl.shamt = shamtF;
        ctrl.aluOp = `CPU_ALU_ADD;
        case (opcode)
            `CPU_OP_ALU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp = aluF;
                ctrl.isMul = (aluF == `CPU_ALU_MUL);
                usesA = 1'b1;
                usesB = 1'b1;
            end
            `CPU_OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                usesA = 1'b1;
            end
            `CPU_OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.memRead = 1'b1;
                usesA = 1'b1;
            end
            // address from rs, store data from rd on port B
            `CPU_OP_SW: begin
                ctrl.useImm = 1'b1;
                ctrl.memWrite = 1'b1;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            `CPU_OP_BNE: begin
                ctrl.isBranchNe = 1'b1;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            `CPU_OP_BLT: begin
                ctrl.isBranchLt = 1'b1;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            `CPU_OP_J: begin
                ctrl.isJump = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // branches compare rd against rs, sw stores rd
    assign isBranch = (opcode == `CPU_OP_BNE) || (opcode == `CPU_OP_BLT);
    assign idxA = isBranch ? rdF : rsF;
    assign idxB = isBranch ? rsF : ((opcode == `CPU_OP_SW) ? rdF : rtF);

    assign ctrlReadRegA = idxA;
    assign ctrlReadRegB = idxB;
    assign hz.srcA = idxA;
    assign hz.srcB = idxB;
    assign hz.readA = fd.valid & usesA;
    assign hz.readB = fd.valid & usesB;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            dx.valid <= 1'b0;
        end else if (!hz.mulBusy) begin
            // bubble on load-use stall or on a squash from execute
            dx.valid <= fd.valid & !hz.stallFront & !redirect;
            dx.pc <= fd.pc;
            dx.rsVal <= dataReadRegA;
            dx.rtVal <= dataReadRegB;
            dx.imm <= immExt;
            dx.target <= tgtExt;
            dx.rd <= rdF;
            // unread sources become r0 so they never match a forward
            dx.srcA <= usesA ? idxA : '0;
            dx.srcB <= usesB ? idxB : '0;
            dx.ctrl <= ctrl;
        end
    end

endmodule

//--- rtl/executeUnit.sv
/*
 * execute stage with forwarding, ALU, branch resolution and the
 * iterative shift-add multiplier
 * branches and jumps resolve here and squash two younger slots
 * mul yields the low 32 bits of the product only
 */
`include "cpuConsts.svh"

module executeUnit import cpuPkg::*; (
    input  logic     clock,
    input  logic     rstN,
    hazardIf.execute hz,
    input  dxRegT    dx,
    input  mwRegT    mw,
    output logic     redirect,
    output wordT     redirectPc,
    output xmRegT    xm
);

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluOut;
    wordT branchPc;
    logic takeNe;
    logic takeLt;
    // multiplier state
    wordT mcand;
    wordT mplier;
    wordT acc;
    wordT stepSum;

    // forwarding, the newer stage is already chosen by the controller
    always_comb begin
        case (hz.fwdSelA)
            fromXm:  opA = xm.result;
            fromMw:  opA = wbValue(mw);
            default: opA = dx.rsVal;
        endcase
        case (hz.fwdSelB)
            fromXm:  opB = xm.result;
            fromMw:  opB = wbValue(mw);
            default: opB = dx.rtVal;
        endcase
    end

    assign aluB = dx.ctrl.useImm ? dx.imm : opB;

    // also forms load and store addresses as rs + imm
    always_comb begin
        case (dx.ctrl.aluOp)
            `CPU_ALU_ADD: aluOut = opA + aluB;
            `CPU_ALU_SUB: aluOut = opA - aluB;
            `CPU_ALU_AND: aluOut = opA & aluB;
            `CPU_ALU_OR:  aluOut = opA | aluB;
            `CPU_ALU_SLL: aluOut = opA << dx.ctrl.shamt;
            `CPU_ALU_SRA: aluOut = $signed(opA) >>> dx.ctrl.shamt;
            default:      aluOut = '0;
        endcase
    end

    // port A holds rd and port B holds rs for branches
    assign takeNe = dx.ctrl.isBranchNe && (opA != opB);
    assign takeLt = dx.ctrl.isBranchLt && ($signed(opA) < $signed(opB));
    assign branchPc = dx.pc + wordT'(1) + dx.imm;

    assign redirect = dx.valid & (takeNe | takeLt | dx.ctrl.isJump);
    assign redirectPc = dx.ctrl.isJump ? dx.target : branchPc;

    // one partial product per cycle, multiplier bits taken LSB first
    assign stepSum = acc + (mplier[0] ? mcand : '0);

    always_ff @(posedge clock) begin
        if (hz.mulStart) begin
            acc <= '0;
            mcand <= opA;
            mplier <= opB;
        end else if (hz.mulBusy) begin
            acc <= stepSum;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // last step is folded in combinationally on the done cycle
    always_ff @(posedge clock) begin
        if (!rstN) begin
            xm.valid <= 1'b0;
        end else begin
            xm.valid <= dx.valid & !hz.mulBusy;
            xm.result <= hz.mulDone ? stepSum : aluOut;
            xm.storeData <= opB;
            xm.rd <= dx.rd;
            xm.regWrite <= dx.ctrl.regWrite;
            xm.memWrite <= dx.ctrl.memWrite;
            xm.memRead <= dx.ctrl.memRead;
        end
    end

endmodule

//--- rtl/hazardControl.sv
/*
 * hazard controller for the pipeline
 * run / multiply-busy FSM, load-use stall and forwarding selects
 * a load never sits in the memory stage with a dependent in execute,
 * the load-use stall puts a bubble between them
 */
module hazardControl import cpuPkg::*; (
    input  logic   clock,
    input  logic   rstN,
    hazardIf.ctrl  hz,
    input  dxRegT  dx,
    input  xmRegT  xm,
    input  mwRegT  mw
);

    typedef enum logic {
        stateRun,
        stateMulBusy
    } mulStateT;

    mulStateT state;
    logic     loadHitA;
    logic     loadHitB;

    // newest producer of src wins, r0 never forwards
    function automatic fwdSelT pickFwd(regAddrT src, xmRegT x, mwRegT m);
        if (src == '0) begin
            return none;
        end
        if (x.valid && x.regWrite && (x.rd == src)) begin
            return fromXm;
        end
        if (m.valid && m.regWrite && (m.rd == src)) begin
            return fromMw;
        end
        return none;
    endfunction

    assign hz.fwdSelA = pickFwd(dx.srcA, xm, mw);
    assign hz.fwdSelB = pickFwd(dx.srcB, xm, mw);

    // load in execute feeding the instruction in decode
    assign loadHitA = hz.readA && (hz.srcA == dx.rd);
    assign loadHitB = hz.readB && (hz.srcB == dx.rd);
    assign hz.stallFront = dx.valid && dx.ctrl.memRead && (dx.rd != '0)
                           && (loadHitA || loadHitB);

    // mul in execute starts the counter once, then holds until done
    assign hz.mulStart = (state == stateRun) && dx.valid && dx.ctrl.isMul;
    // released on the done cycle so the product and the next op advance
    assign hz.mulBusy = hz.mulStart || ((state == stateMulBusy) && !hz.mulDone);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= stateRun;
        end else begin
            case (state)
                stateRun: begin
                    if (hz.mulStart) begin
                        state <= stateMulBusy;
                    end
                end
                stateMulBusy: begin
                    if (hz.mulDone) begin
                        state <= stateRun;
                    end
                end
                default: state <= stateRun;
            endcase
        end
    end

    mulStepCounter stepCounter (
        .clock (clock),
        .rstN  (rstN),
        .start (hz.mulStart),
        .done  (hz.mulDone)
    );

    assert property (@(posedge clock) disable iff (!rstN) hz.mulDone |-> state == stateMulBusy)
        else $error("multiply done outside the busy state");

endmodule

//--- rtl/memWriteback.sv
/*
 * memory stage and writeback drive
 * data memory is addressed straight from execute/memory
 * and the read data is registered into memory/writeback
 * writes to r0 never reach the register file
 */
module memWriteback import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  xmRegT   xm,
    output wordT    addressDmem,
    output wordT    data,
    output logic    wren,
    input  wordT    qDmem,
    output mwRegT   mw,
    output logic    ctrlWriteEnable,
    output regAddrT ctrlWriteReg,
    output wordT    dataWriteReg
);

    assign addressDmem = xm.result;
    assign data = xm.storeData;
    // bubbles must not write memory
    assign wren = xm.valid & xm.memWrite;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mw.valid <= 1'b0;
        end else begin
            mw.valid <= xm.valid;
            mw.result <= xm.result;
            mw.loadData <= qDmem;
            mw.rd <= xm.rd;
            mw.regWrite <= xm.regWrite;
            mw.memRead <= xm.memRead;
        end
    end

    // register file writes at the end of this cycle, write-through to decode
    assign ctrlWriteEnable = mw.valid & mw.regWrite & (mw.rd != '0);
    assign ctrlWriteReg = mw.rd;
    assign dataWriteReg = wbValue(mw);

    assert property (@(posedge clock) disable iff (!rstN)
                     ctrlWriteEnable |-> ctrlWriteReg != '0)
        else $error("register file write to r0");

endmodule

//--- rtl/cpuTop.sv
/*
 * five-stage pipelined integer core
 * instruction memory, data memory and register file live outside
 * both memories must answer combinationally in the same cycle
 * the register file must be write-through and read r0 as zero
 */
module cpuTop import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    // instruction memory
    output wordT    addressImem,
    input  wordT    qImem,
    // data memory
    output wordT    addressDmem,
    output wordT    data,
    output logic    wren,
    input  wordT    qDmem,
    // register file
    output logic    ctrlWriteEnable,
    output regAddrT ctrlWriteReg,
    output regAddrT ctrlReadRegA,
    output regAddrT ctrlReadRegB,
    output wordT    dataWriteReg,
    input  wordT    dataReadRegA,
    input  wordT    dataReadRegB
);

    hazardIf hz ();

    // stage registers passed forward
    fdRegT fd;
    dxRegT dx;
    xmRegT xm;
    mwRegT mw;
    // taken branch or jump from execute
    logic  redirect;
    wordT  redirectPc;

    fetchUnit fetch (
        .clock       (clock),
        .rstN        (rstN),
        .hz          (hz.fetch),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .addressImem (addressImem),
        .qImem       (qImem),
        .fd          (fd)
    );

    decodeUnit decode (
        .clock        (clock),
        .rstN         (rstN),
        .hz           (hz.decode),
        .fd           (fd),
        .redirect     (redirect),
        .ctrlReadRegA (ctrlReadRegA),
        .ctrlReadRegB (ctrlReadRegB),
        .dataReadRegA (dataReadRegA),
        .dataReadRegB (dataReadRegB),
        .dx           (dx)
    );

    executeUnit execute (
        .clock      (clock),
        .rstN       (rstN),
        .hz         (hz.execute),
        .dx         (dx),
        .mw         (mw),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .xm         (xm)
    );

    hazardControl hazard (
        .clock (clock),
        .rstN  (rstN),
        .hz    (hz.ctrl),
        .dx    (dx),
        .xm    (xm),
        .mw    (mw)
    );

    memWriteback memWb (
        .clock           (clock),
        .rstN            (rstN),
        .xm              (xm),
        .addressDmem     (addressDmem),
        .data            (data),
        .wren            (wren),
        .qDmem           (qDmem),
        .mw              (mw),
        .ctrlWriteEnable (ctrlWriteEnable),
        .ctrlWriteReg    (ctrlWriteReg),
        .dataWriteReg    (dataWriteReg)
    );

endmodule

//--- test/clockGen.sv
/*
 * 40 ns clock and synchronous active-low reset for the testbench
 * rstN starts low and only changes on falling edges
 * enterReset plus leaveReset hold reset for four rising edges
 */
module clockGen (
    output logic clock,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int halfPeriod = 20;

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
    end

    always #halfPeriod clock = ~clock;

    // first rising edge in reset clears every valid bit
    task automatic enterReset();
        @(negedge clock);
        rstN = 1'b0;
        @(negedge clock);
    endtask

    // three more rising edges complete the reset
    task automatic leaveReset();
        repeat (3) @(negedge clock);
        rstN = 1'b1;
    endtask

endmodule

//--- test/cpuMemModel.sv
/*
 * behavioral memories and register file around the core
 * instruction and data memory hold 256 words, reads are combinational
 * addresses past the last word read as zero, which decodes as a no-op
 * register file writes on the rising edge and is write-through
 */
module cpuMemModel import cpuPkg::*; (
    input  logic    clock,
    input  wordT    addressImem,
    output wordT    qImem,
    input  wordT    addressDmem,
    input  wordT    data,
    input  logic    wren,
    output wordT    qDmem,
    input  logic    ctrlWriteEnable,
    input  regAddrT ctrlWriteReg,
    input  regAddrT ctrlReadRegA,
    input  regAddrT ctrlReadRegB,
    input  wordT    dataWriteReg,
    output wordT    dataReadRegA,
    output wordT    dataReadRegB
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int memWords = 256;

    wordT imem [memWords];
    wordT dmem [memWords];
    wordT regs [32];

    assign qImem = (addressImem < memWords) ? imem[addressImem[7:0]] : '0;
    assign qDmem = (addressDmem < memWords) ? dmem[addressDmem[7:0]] : '0;

    // r0 reads zero, a same-cycle write is seen by the read
    assign dataReadRegA = (ctrlReadRegA == '0) ? '0 :
        ((ctrlWriteEnable && ctrlWriteReg == ctrlReadRegA) ? dataWriteReg : regs[ctrlReadRegA]);
    assign dataReadRegB = (ctrlReadRegB == '0) ? '0 :
        ((ctrlWriteEnable && ctrlWriteReg == ctrlReadRegB) ? dataWriteReg : regs[ctrlReadRegB]);

    always @(posedge clock) begin
        if (wren && addressDmem < memWords) begin
            dmem[addressDmem[7:0]] <= data;
        end
        // storage of r0 is written too, so a stray write stays visible
        if (ctrlWriteEnable) begin
            regs[ctrlWriteReg] <= dataWriteReg;
        end
    end

    // program memory of no-ops, data words tagged with their own address
    task automatic clearAll();
        int i;
        for (i = 0; i < memWords; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd0d00000 ^ wordT'(i);
        end
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
    endtask

    initial begin
        clearAll();
    end

endmodule

//--- test/cpuTb.sv
/*
 * directed tests for the five-stage core
 * each test loads a program, resets and runs it until a store
 * to data word 255, then checks registers and data memory
 * register presets go straight into the register file model
 */
`include "cpuConsts.svh"

module cpuTb import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int haltTimeout = 400;

    logic    clock;
    logic    rstN;
    wordT    addressImem;
    wordT    qImem;
    wordT    addressDmem;
    wordT    data;
    logic    wren;
    wordT    qDmem;
    logic    ctrlWriteEnable;
    regAddrT ctrlWriteReg;
    regAddrT ctrlReadRegA;
    regAddrT ctrlReadRegB;
    wordT    dataWriteReg;
    wordT    dataReadRegA;
    wordT    dataReadRegB;

    int      errorCount = 0;
    int      checkCount = 0;
    wordT    rngState;
    wordT    prog [$];

    clockGen u_clk (.*);
    cpuMemModel u_mem (.*);
    cpuTop u_dut (.*);

    function automatic wordT xorshift32(wordT x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic wordT randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // instruction encoders, fields as in the ISA
    function automatic wordT encAlu(logic [4:0] aluOp, regAddrT rd, regAddrT rs, regAddrT rt,
                                    logic [4:0] shamt);
        return {`CPU_OP_ALU, rd, rs, rt, shamt, aluOp, 2'b00};
    endfunction

    function automatic wordT encImm(logic [4:0] op, regAddrT rd, regAddrT rs, logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic wordT encJump(logic [26:0] target);
        return {`CPU_OP_J, target};
    endfunction

    task automatic checkEq(input string name, input wordT got, input wordT expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("Error: %s is %h, expected %h", name, got, expected);
        end
    endtask

    task automatic checkReg(input int idx, input wordT expected);
        checkEq($sformatf("r%0d", idx), u_mem.regs[idx], expected);
    endtask

    // r0 must never reach the register file write port
    always @(negedge clock) begin
        if (rstN && ctrlWriteReg == '0) begin
            checkEq("ctrlWriteEnable", wordT'(ctrlWriteEnable), '0);
        end
    end

    task automatic prepareTest();
        u_clk.enterReset();
        u_mem.clearAll();
        prog.delete();
    endtask

    task automatic runProgram(input string name, output logic finished);
        int i;
        int cycles;
        for (i = 0; i < prog.size(); i++) begin
            u_mem.imem[i] = prog[i];
        end
        // sw r0, 255(r0) marks the end of every program
        u_mem.imem[prog.size()] = encImm(`CPU_OP_SW, 5'd0, 5'd0, 17'd255);
        u_clk.leaveReset();
        finished = 1'b0;
        cycles = 0;
        while (!finished && cycles < haltTimeout) begin
            @(negedge clock);
            cycles++;
            if (wren === 1'b1 && addressDmem === 32'd255) begin
                finished = 1'b1;
            end
        end
        if (finished) begin
            // older instructions retire behind the halt store
            repeat (2) @(negedge clock);
        end else begin
            errorCount++;
            $display("Timeout: test %s never reached its halt store", name);
        end
    endtask

    task automatic aluChainTest();
        logic        finished;
        logic [16:0] imm;
        wordT        a;
        wordT        b;
        wordT        immExt;
        wordT        exp3, exp4, exp5, exp6, exp7, exp8, exp9, exp10;
        prepareTest();
        a = randWord();
        b = randWord();
        imm = 17'(randWord());
        immExt = {{(32 - 17){imm[16]}}, imm};
        u_mem.regs[1] = a;
        u_mem.regs[2] = b;
        // each op consumes the one before it, some two back
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_AND, 5'd5, 5'd3, 5'd4, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_OR, 5'd6, 5'd5, 5'd2, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_SLL, 5'd7, 5'd6, 5'd0, 5'd5));
        prog.push_back(encAlu(`CPU_ALU_SRA, 5'd8, 5'd7, 5'd0, 5'd3));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd9, 5'd8, imm));
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd10, 5'd9, 5'd3, 5'd0));
        exp3 = a + b;
        exp4 = exp3 - a;
        exp5 = exp3 & exp4;
        exp6 = exp5 | b;
        exp7 = exp6 << 5;
        exp8 = wordT'($signed(exp7) >>> 3);
        exp9 = exp8 + immExt;
        exp10 = exp9 + exp3;
        runProgram("alu chain", finished);
        if (finished) begin
            checkReg(3, exp3);
            checkReg(4, exp4);
            checkReg(5, exp5);
            checkReg(6, exp6);
            checkReg(7, exp7);
            checkReg(8, exp8);
            checkReg(9, exp9);
            checkReg(10, exp10);
        end
    endtask

    task automatic loadUseTest();
        logic finished;
        wordT c;
        prepareTest();
        c = randWord();
        u_mem.regs[1] = c;
        u_mem.regs[2] = 32'd20;
        prog.push_back(encImm(`CPU_OP_SW, 5'd1, 5'd2, 17'd3));
        prog.push_back(encImm(`CPU_OP_LW, 5'd3, 5'd2, 17'd3));
        // loaded value used by the very next instruction
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd4, 5'd3, 5'd3, 5'd0));
        prog.push_back(encImm(`CPU_OP_SW, 5'd4, 5'd2, 17'd4));
        prog.push_back(encImm(`CPU_OP_LW, 5'd5, 5'd2, 17'd3));
        // store data taken straight from a load
        prog.push_back(encImm(`CPU_OP_SW, 5'd5, 5'd2, 17'd5));
        runProgram("load use", finished);
        if (finished) begin
            checkReg(3, c);
            checkReg(4, c + c);
            checkReg(5, c);
            checkEq("dmem[23]", u_mem.dmem[23], c);
            checkEq("dmem[24]", u_mem.dmem[24], c + c);
            checkEq("dmem[25]", u_mem.dmem[25], c);
        end
    endtask

    task automatic branchTest();
        logic finished;
        wordT x;
        wordT y;
        prepareTest();
        x = randWord();
        y = randWord();
        if (x == y) begin
            y = ~x;
        end
        u_mem.regs[1] = x;
        u_mem.regs[2] = y;
        // r3 holds the signed larger value so blt r3, r4 falls through
        if ($signed(x) < $signed(y)) begin
            u_mem.regs[3] = y;
            u_mem.regs[4] = x;
        end else begin
            u_mem.regs[3] = x;
            u_mem.regs[4] = y;
        end
        prog.push_back(encImm(`CPU_OP_BNE, 5'd1, 5'd2, 17'd2));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd10, 5'd0, 17'd10));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd11, 5'd0, 17'd11));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd12, 5'd0, 17'd12));
        prog.push_back(encImm(`CPU_OP_BLT, 5'd3, 5'd4, 17'd5));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd13, 5'd0, 17'd13));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd14, 5'd0, 17'd14));
        prog.push_back(encJump(27'd10));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd15, 5'd0, 17'd15));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd16, 5'd0, 17'd16));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd17, 5'd0, 17'd17));
        runProgram("branches", finished);
        if (finished) begin
            checkReg(10, '0);
            checkReg(11, '0);
            checkReg(12, 32'd12);
            checkReg(13, 32'd13);
            checkReg(14, 32'd14);
            checkReg(15, '0);
            checkReg(16, '0);
            checkReg(17, 32'd17);
        end
    endtask

    task automatic mulTest();
        logic finished;
        wordT a;
        wordT b;
        wordT prod1;
        wordT sum4;
        wordT prod2;
        prepareTest();
        a = randWord();
        b = randWord();
        u_mem.regs[1] = a;
        u_mem.regs[2] = b;
        prog.push_back(encAlu(`CPU_ALU_MUL, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd4, 5'd3, 5'd1, 5'd0));
        // second mul takes an operand from the add just ahead of it
        prog.push_back(encAlu(`CPU_ALU_MUL, 5'd5, 5'd4, 5'd2, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_SUB, 5'd6, 5'd5, 5'd3, 5'd0));
        prod1 = a * b;
        sum4 = prod1 + a;
        prod2 = sum4 * b;
        runProgram("multiply", finished);
        if (finished) begin
            checkReg(3, prod1);
            checkReg(4, sum4);
            checkReg(5, prod2);
            checkReg(6, prod2 - prod1);
        end
    endtask

    task automatic zeroRegTest();
        logic finished;
        wordT a;
        prepareTest();
        a = randWord() | 32'd1;
        u_mem.regs[1] = a;
        u_mem.regs[3] = randWord() | 32'd1;
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd0, 5'd1, 17'd7));
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd2, 5'd0, 5'd1, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_ADD, 5'd0, 5'd1, 5'd1, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_OR, 5'd3, 5'd0, 5'd0, 5'd0));
        prog.push_back(encAlu(`CPU_ALU_SLL, 5'd0, 5'd1, 5'd0, 5'd2));
        prog.push_back(encImm(`CPU_OP_ADDI, 5'd4, 5'd0, 17'd9));
        runProgram("register zero", finished);
        if (finished) begin
            checkReg(2, a);
            checkReg(3, '0);
            checkReg(4, 32'd9);
            checkReg(0, '0);
        end
    endtask

    initial begin
        rngState = 32'hbd72;
        $display("running alu chain");
        aluChainTest();
        $display("running load use");
        loadUseTest();
        $display("running branches");
        branchTest();
        $display("running multiply");
        mulTest();
        $display("running register zero");
        zeroRegTest();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/hazardIf.sv
rtl/mulStepCounter.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/executeUnit.sv
rtl/hazardControl.sv
rtl/memWriteback.sv
rtl/cpuTop.sv
test/clockGen.sv
test/cpuMemModel.sv
test/cpuTb.sv
